/* Makefile */
# Verilator build and run of the block mover testbench
VERILATOR ?= verilator
TOP       ?= tb_block_mover
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LATENCY   ?= 3
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GMCU_LATENCY=$(LATENCY) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
logic/mover_pkg.sv
logic/mem_bus_pkg.sv
logic/mover_fsm.sv
logic/mover_drain_timer.sv
logic/mcu_read_issuer.sv
logic/lsab_writer.sv
logic/block_mover_top.sv
verification/mover_dram_model.sv
verification/tb_block_mover.sv

/* logic/block_mover_top.sv */
// ----------------------------------------------------------------------
// DRAM to LSAB block mover
// control FSM, MCU read issuer, latency-matched LSAB writer and drain
// timer; MCU latency is set here and handed to the timed blocks
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module block_mover_top #(
	parameter int MCU_LATENCY = 3   // request to data, 2..6
) (
	input  logic                            CLK,
	input  logic                            RST,
	// command port
	input  mover_pkg::move_cmd_t            cmd,
	input  logic                            issue,
	output logic                            working,
	output mover_pkg::move_status_t         status,
	// mcu
	output mem_bus_pkg::mcu_req_t           mcu_req,
	input  mem_bus_pkg::mcu_rsp_t           mcu_rsp,
	// lsab
	input  logic [mover_pkg::SECTION_N-1:0] lsab_full,
	input  logic [mover_pkg::SECTION_N-1:0] dev_err,
	output logic [mover_pkg::SECTION_N-1:0] dev_err_ack,
	output mem_bus_pkg::lsab_wr_t           lsab_wr
);

	logic                         read_en, drain_start, drain_done;
	logic                         accept, req_fire;
	mover_pkg::addr_t             start_addr;
	mover_pkg::section_t          section;
	mover_pkg::dram_sel_t         dram_sel;
	mover_pkg::move_status_t      fsm_status;   // flags only
	logic [mover_pkg::LEN_W-1:0]  count_sent;

	assign accept   = issue & ~working;             // same rule as the fsm
	assign req_fire = |mcu_req.access;              // request on the bus
	assign status   = '{count_sent: count_sent,
	                    abrupt_stop: fsm_status.abrupt_stop,
	                    device_error: fsm_status.device_error};

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------
	mover_fsm u_fsm (
		.CLK         (CLK),
		.RST         (RST),
		.cmd         (cmd),
		.issue       (issue),
		.lsab_full   (lsab_full),
		.dev_err     (dev_err),
		.drain_done  (drain_done),
		.read_en     (read_en),
		.last_req    (),                        // not needed at this level
		.start_addr  (start_addr),
		.section     (section),
		.dram_sel    (dram_sel),
		.drain_start (drain_start),
		.working     (working),
		.dev_err_ack (dev_err_ack),
		.status      (fsm_status)
	);

	mover_drain_timer #(.MCU_LATENCY(MCU_LATENCY)) u_drain (
		.CLK         (CLK),
		.RST         (RST),
		.drain_start (drain_start),
		.drain_done  (drain_done)
	);

	// ------------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------------
	mcu_read_issuer u_issuer (
		.CLK        (CLK),
		.RST        (RST),
		.read_en    (read_en),
		.start_addr (start_addr),
		.load       (accept),
		.dram_sel   (dram_sel),
		.mcu_req    (mcu_req)
	);

	lsab_writer #(.MCU_LATENCY(MCU_LATENCY)) u_writer (
		.CLK        (CLK),
		.RST        (RST),
		.req_fire   (req_fire),
		.clear      (accept),
		.section    (section),
		.mcu_rsp    (mcu_rsp),
		.lsab_wr    (lsab_wr),
		.count_sent (count_sent)
	);

endmodule

/* logic/lsab_writer.sv */
// ----------------------------------------------------------------------
// LSAB write stage of the block mover
// carries each request strobe through a shift register as deep as the
// MCU latency and writes the returning word to the selected section,
// counting the words sent
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module lsab_writer #(
	parameter int MCU_LATENCY = 3   // 2..6
) (
	input  logic                           CLK,
	input  logic                           RST,
	input  logic                           req_fire,    // request on the mcu bus
	input  logic                           clear,       // command accepted
	input  mover_pkg::section_t            section,
	input  mem_bus_pkg::mcu_rsp_t          mcu_rsp,
	output mem_bus_pkg::lsab_wr_t          lsab_wr,
	output logic [mover_pkg::LEN_W-1:0]    count_sent
);

	logic [MCU_LATENCY-1:0] fire_pipe_q;   // one bit per read in flight
	logic                   wr_now;

	// ------------------------------------------------------------------
	// latency pipe
	// ------------------------------------------------------------------
	// bit 0 is one cycle after the request, top bit lines up with data
	always_ff @(posedge CLK)
	begin
		if (!RST)
			fire_pipe_q <= '0;
		else
			fire_pipe_q <= {fire_pipe_q[MCU_LATENCY-2:0], req_fire};
	end

	assign wr_now = fire_pipe_q[MCU_LATENCY-1];  // data valid on mcu_rsp

	// response passes straight through, no extra cycle
	assign lsab_wr = '{write: wr_now, section: section, data: mcu_rsp.data};

	// ------------------------------------------------------------------
	// words sent
	// ------------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (!RST)
			count_sent <= '0;
		else if (clear)
			count_sent <= '0;               // fresh move
		else if (wr_now)
			count_sent <= count_sent + 1'b1;
	end

endmodule

/* logic/mcu_read_issuer.sv */
// ----------------------------------------------------------------------
// MCU read request generator
// word address counter and registered request toward the MCU, one
// address per cycle while the FSM enables reads
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mcu_read_issuer (
	input  logic                  CLK,
	input  logic                  RST,
	input  logic                  read_en,     // request next cycle
	input  mover_pkg::addr_t      start_addr,  // already pair aligned
	input  logic                  load,        // command accepted
	input  mover_pkg::dram_sel_t  dram_sel,
	output mem_bus_pkg::mcu_req_t mcu_req
);

	mover_pkg::dram_sel_t access_q;   // registered with fsm state
	mover_pkg::addr_t     addr_q;
	logic                 issued_q;   // request on the bus this cycle

	// ------------------------------------------------------------------
	// request strobe
	// ------------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			access_q <= '0;
			issued_q <= 1'b0;
		end
		else
		begin
			access_q <= read_en ? dram_sel : '0;   // port gated by enable
			issued_q <= read_en;
		end
	end

	// ------------------------------------------------------------------
	// address counter
	// ------------------------------------------------------------------
	always_ff @(posedge CLK)
	begin
		if (load)
			addr_q <= start_addr;           // first request address
		else if (issued_q)
			addr_q <= addr_q + 1'b1;        // step past the one just sent
	end

	assign mcu_req = '{access: access_q, address: addr_q};

endmodule

/* logic/mem_bus_pkg.sv */
// ----------------------------------------------------------------------
// memory side bus types
// MCU read request/response and LSAB write port of the block mover
// ----------------------------------------------------------------------
package mem_bus_pkg;

	localparam int DATA_W = 16;  // dram word

	typedef logic [DATA_W-1:0] data_t;

	// ------------------------------------------------------------------
	// mcu read port
	// ------------------------------------------------------------------
	typedef struct packed {
		mover_pkg::dram_sel_t access;   // per-port request, zero = idle
		mover_pkg::addr_t     address;  // word address
	} mcu_req_t;                        // 11 bits

	// data only, arrives at fixed latency so no valid bit
	typedef struct packed {
		data_t data;
	} mcu_rsp_t;

	// ------------------------------------------------------------------
	// lsab write port
	// ------------------------------------------------------------------
	typedef struct packed {
		logic                write;    // one cycle strobe
		mover_pkg::section_t section;  // target section
		data_t               data;     // word to store
	} lsab_wr_t;                       // 19 bits

endpackage

/* logic/mover_drain_timer.sv */
// ----------------------------------------------------------------------
// drain timer of the block mover
// counts out the MCU read latency after the final request so the busy
// phase ends right after the last LSAB write
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mover_drain_timer #(
	parameter int MCU_LATENCY = 3   // request to data, cycles
) (
	input  logic CLK,
	input  logic RST,
	input  logic drain_start,       // cycle of the last request
	output logic drain_done         // cycle of the last write
);

	localparam int CNT_W = $clog2(MCU_LATENCY + 1);

	logic [CNT_W-1:0] cnt_q;        // zero = idle

	// ------------------------------------------------------------------
	// down-counter
	// ------------------------------------------------------------------
	// window is MCU_LATENCY+1 cycles counting the start cycle itself,
	// so done lines up with the write of the final in-flight word
	always_ff @(posedge CLK)
	begin
		if (!RST)
			cnt_q <= '0;
		else if (drain_start)
			cnt_q <= CNT_W'(MCU_LATENCY);   // load full latency
		else if (cnt_q != '0)
			cnt_q <= cnt_q - 1'b1;          // tick down to idle
	end

	assign drain_done = (cnt_q == CNT_W'(1));  // expires next edge

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// fsm must not restart a drain that is still counting
	a_start_when_idle: assert property (@(posedge CLK) disable iff (!RST)
		drain_start |-> (cnt_q == '0));

endmodule

/* logic/mover_fsm.sv */
// ----------------------------------------------------------------------
// block mover control FSM
// accepts one move command at a time, aligns the length to word pairs,
// counts down the read requests, stops early on section full or device
// error and keeps the status flags and error acknowledge
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mover_fsm (
	input  logic                            CLK,
	input  logic                            RST,
	input  mover_pkg::move_cmd_t            cmd,
	input  logic                            issue,
	input  logic [mover_pkg::SECTION_N-1:0] lsab_full,
	input  logic [mover_pkg::SECTION_N-1:0] dev_err,
	input  logic                            drain_done,
	output logic                            read_en,
	output logic                            last_req,
	output mover_pkg::addr_t                start_addr,
	output mover_pkg::section_t             section,
	output mover_pkg::dram_sel_t            dram_sel,
	output logic                            drain_start,
	output logic                            working,
	output logic [mover_pkg::SECTION_N-1:0] dev_err_ack,
	output mover_pkg::move_status_t         status
);

	mover_pkg::mover_state_e       state_q, state_d;
	logic [mover_pkg::LEN_W:0]     rem_q;       // requests left after current one
	logic [mover_pkg::LEN_W:0]     rem_init;
	mover_pkg::addr_t              end_addr;    // last word wanted
	logic [mover_pkg::ADDR_W-2:0]  pair_diff;   // pairs spanned minus one
	mover_pkg::section_t           section_q;
	mover_pkg::dram_sel_t          sel_q;
	logic                          accept, in_read, full_sel, err_sel, stop;
	logic                          abrupt_q, dev_error_q;

	// ------------------------------------------------------------------
	// command decode and length alignment
	// ------------------------------------------------------------------
	assign working    = (state_q != mover_pkg::IDLE);
	assign accept     = issue && !working;                  // issue while busy dropped
	assign start_addr = {cmd.start_addr[mover_pkg::ADDR_W-1:1], 1'b0};  // even word
	assign end_addr   = cmd.start_addr + mover_pkg::ADDR_W'(cmd.count_req);
	assign pair_diff  = end_addr[mover_pkg::ADDR_W-1:1] - cmd.start_addr[mover_pkg::ADDR_W-1:1];
	assign rem_init   = {pair_diff[mover_pkg::LEN_W-1:0], 1'b1};  // aligned words minus one

	// sel must be live on the accept cycle, latched after
	assign dram_sel = working ? sel_q : cmd.dram_sel;
	assign section  = section_q;

	// ------------------------------------------------------------------
	// stop conditions and request enable
	// ------------------------------------------------------------------
	assign in_read     = (state_q == mover_pkg::READ);
	assign full_sel    = lsab_full[section_q];              // only our section counts
	assign err_sel     = dev_err[section_q];
	assign stop        = in_read && (full_sel || err_sel);
	assign last_req    = in_read && (rem_q == '0);          // bus holds final request
	assign read_en     = accept || (in_read && (rem_q != '0) && !stop);  // next cycle requests
	assign drain_start = in_read && !read_en;               // leaving READ

	always_comb
	begin
		state_d = state_q;
		unique case (state_q)
			mover_pkg::IDLE:
				if (accept)
					state_d = mover_pkg::READ;
			mover_pkg::READ:
				if (drain_start)
					state_d = mover_pkg::DRAIN;  // last request or stop
			mover_pkg::DRAIN:
				if (drain_done)
					state_d = mover_pkg::IDLE;   // final write just landed
			default:
				state_d = mover_pkg::IDLE;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state_q     <= mover_pkg::IDLE;
			rem_q       <= '0;
			abrupt_q    <= 1'b0;
			dev_error_q <= 1'b0;
			dev_err_ack <= '0;
		end
		else
		begin
			state_q     <= state_d;
			dev_err_ack <= '0;                          // pulse only
			if (accept)
			begin
				rem_q       <= rem_init;
				abrupt_q    <= 1'b0;                    // new move clears status
				dev_error_q <= 1'b0;
			end
			else if (in_read && read_en)
				rem_q <= rem_q - 1'b1;
			if (stop)
			begin
				abrupt_q    <= 1'b1;
				dev_error_q <= err_sel;
				dev_err_ack <= err_sel ? (mover_pkg::SECTION_N'(1) << section_q) : '0;
			end
		end
	end

	// command payload, held for the whole move
	always_ff @(posedge CLK)
	begin
		if (accept)
		begin
			section_q <= cmd.section;
			sel_q     <= cmd.dram_sel;
		end
	end

	assign status = '{count_sent: '0, abrupt_stop: abrupt_q, device_error: dev_error_q};

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	// READ is only ever entered straight from an accepted command
	a_accept_idle_only: assert property (@(posedge CLK) disable iff (!RST)
		(in_read && $past(state_q) != mover_pkg::READ) |->
		$past(state_q == mover_pkg::IDLE && issue));

	a_no_read_drain: assert property (@(posedge CLK) disable iff (!RST)
		(state_q == mover_pkg::DRAIN) |-> (!read_en && !drain_start));

endmodule

/* logic/mover_pkg.sv */
// ----------------------------------------------------------------------
// block mover command side types
// widths, command word, status word and the FSM state encoding
// shared by the mover control and datapath blocks
// ----------------------------------------------------------------------
package mover_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int ADDR_W    = 9;  // dram word address
	localparam int LEN_W     = 6;  // length / word count
	localparam int SECTION_N = 4;  // lsab sections
	localparam int DRAM_N    = 2;  // dram ports, one access bit each

	typedef logic [ADDR_W-1:0]            addr_t;
	typedef logic [LEN_W-1:0]             len_t;
	typedef logic [$clog2(SECTION_N)-1:0] section_t;
	typedef logic [DRAM_N-1:0]            dram_sel_t;

	// ------------------------------------------------------------------
	// command and status words
	// ------------------------------------------------------------------
	typedef struct packed {
		addr_t     start_addr;  // first word wanted, any alignment
		len_t      count_req;   // words minus one
		section_t  section;     // destination lsab section
		dram_sel_t dram_sel;    // which dram port(s) to hit
	} move_cmd_t;               // 19 bits

	typedef struct packed {
		len_t count_sent;       // words written to lsab
		logic abrupt_stop;      // ended on full or error
		logic device_error;     // ended on error only
	} move_status_t;            // 8 bits

	// ------------------------------------------------------------------
	// fsm states
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,   // waiting for issue
		READ,   // one request per cycle
		DRAIN   // requests done, data still in flight
	} mover_state_e;

endpackage

/* verification/mover_dram_model.sv */
// ----------------------------------------------------------------------
// MCU and DRAM model for the block mover testbench
// answers every read request after a fixed latency with a word made
// from the request address, and a poison word when nothing is due
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mover_dram_model #(
	parameter int MCU_LATENCY = 3   // request to data, cycles
) (
	input  logic                  CLK,
	input  logic                  RST,
	input  mem_bus_pkg::mcu_req_t mcu_req,
	output mem_bus_pkg::mcu_rsp_t mcu_rsp
);

	localparam logic [15:0] POISON = 16'hdead;   // no read due this cycle

	mover_pkg::addr_t       addr_pipe [MCU_LATENCY];  // address of each read in flight
	logic [MCU_LATENCY-1:0] valid_pipe;               // read in flight per stage
	logic                   req_seen;

	assign req_seen = |mcu_req.access;   // either port counts

	// ------------------------------------------------------------------
	// read latency pipe
	// ------------------------------------------------------------------
	always @(posedge CLK)
	begin
		if (!RST)
			valid_pipe <= '0;
		else
			valid_pipe <= {valid_pipe[MCU_LATENCY-2:0], req_seen};
	end

	// stage 0 is one cycle after the request
	always @(posedge CLK)
	begin
		addr_pipe[0] <= mcu_req.address;
		for (int i = 1; i < MCU_LATENCY; i++)
			addr_pipe[i] <= addr_pipe[i-1];   // shift toward the output
	end

	// ------------------------------------------------------------------
	// response
	// ------------------------------------------------------------------
	// word content is 7'h55 above the 9-bit address
	assign mcu_rsp = '{data: valid_pipe[MCU_LATENCY-1] ?
	                        {7'h55, addr_pipe[MCU_LATENCY-1]} : POISON};

endmodule

/* verification/tb_block_mover.sv */
// ----------------------------------------------------------------------
// testbench of the DRAM to LSAB block mover
// random even and odd moves, section full and device error stops,
// issue while busy, request/write checks and handshake timing
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_block_mover #(
	parameter int MCU_LATENCY = 3   // request to data, 2..6
);

	localparam int NUM_CMDS    = 16;
	localparam int TIMEOUT_CYC = 64 * NUM_CMDS + 100;   // cycles for the whole run
	localparam int STOP_NONE   = 0;   // runs to the end
	localparam int STOP_OTHER  = 1;   // error on another section
	localparam int STOP_FULL   = 2;
	localparam int STOP_ERR    = 3;

	logic                            CLK, RST;
	mover_pkg::move_cmd_t            cmd;
	logic                            issue, working;
	mover_pkg::move_status_t         status;
	mem_bus_pkg::mcu_req_t           mcu_req;
	mem_bus_pkg::mcu_rsp_t           mcu_rsp;
	logic [mover_pkg::SECTION_N-1:0] lsab_full, dev_err, dev_err_ack;
	mem_bus_pkg::lsab_wr_t           lsab_wr;

	int                   cyc = 0;          // posedge count
	int                   mismatches = 0;
	int                   failures = 0;     // non-value errors
	mover_pkg::section_t  exp_section;      // context of the running move
	mover_pkg::dram_sel_t exp_sel;
	mover_pkg::addr_t     exp_addr;         // next request address
	mover_pkg::addr_t     addr_q [$];       // reads in flight
	int                   req_cyc_q [$];
	int                   req_count, wr_count, ack_count;
	int                   last_req_cyc = 0;
	int                   accept_cyc = -10;
	logic                 working_prev = 1'b0;
	mover_pkg::addr_t     wr_addr;
	int                   wr_req_cyc;

	block_mover_top #(.MCU_LATENCY(MCU_LATENCY)) UUT (
		.CLK(CLK), .RST(RST), .cmd(cmd), .issue(issue), .working(working), .status(status),
		.mcu_req(mcu_req), .mcu_rsp(mcu_rsp), .lsab_full(lsab_full), .dev_err(dev_err),
		.dev_err_ack(dev_err_ack), .lsab_wr(lsab_wr)
	);

	mover_dram_model #(.MCU_LATENCY(MCU_LATENCY)) u_dram (
		.CLK(CLK), .RST(RST), .mcu_req(mcu_req), .mcu_rsp(mcu_rsp)
	);

	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;   // 8 ns period
	end

	always @(posedge CLK)
		cyc <= cyc + 1;

	// ------------------------------------------------------------------
	// reference model and compare tasks
	// ------------------------------------------------------------------
	// pair aligned span from start to start+count_req
	function automatic int expected_words(input int start, input int count_req);
		int first_word;
		int last_word;
		first_word = start - (start % 2);   // round down to even
		last_word  = start + count_req;
		if (last_word % 2 == 0)
			last_word = last_word + 1;      // round up to odd
		return last_word - first_word + 1;
	endfunction

	task automatic flag_failure(input string what);
		failures++;
		$display("error at cycle %0d: %s", cyc, what);
	endtask

	task automatic check_status(input mover_pkg::move_status_t got,
			input mover_pkg::move_status_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch status: got %h expected %h at cycle %0d", got, exp, cyc);
		end
	endtask

	task automatic check_lsab_wr(input mem_bus_pkg::lsab_wr_t got,
			input mem_bus_pkg::lsab_wr_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch lsab_wr: got %h expected %h at cycle %0d", got, exp, cyc);
		end
	endtask

	task automatic check_req(input mem_bus_pkg::mcu_req_t got,
			input mem_bus_pkg::mcu_req_t exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch mcu_req: got %h expected %h at cycle %0d", got, exp, cyc);
		end
	endtask

	task automatic check_ack(input logic [mover_pkg::SECTION_N-1:0] got,
			input logic [mover_pkg::SECTION_N-1:0] exp);
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch dev_err_ack: got %h expected %h at cycle %0d", got, exp, cyc);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			mismatches++;
			$display("mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
		end
	endtask

	// ------------------------------------------------------------------
	// monitor, sampled mid cycle where everything is settled
	// ------------------------------------------------------------------
	always @(negedge CLK)
	begin
		if (RST)
		begin
			if (mcu_req.access != '0)
			begin
				check_req(mcu_req, mem_bus_pkg::mcu_req_t'{access: exp_sel, address: exp_addr});
				addr_q.push_back(exp_addr);
				req_cyc_q.push_back(cyc);
				exp_addr     = exp_addr + 1'b1;   // one address per cycle
				req_count++;
				last_req_cyc = cyc;
			end
			if (lsab_wr.write)
			begin
				wr_count++;
				if (addr_q.size() == 0)
					flag_failure("lsab write with no read in flight");
				else
				begin
					wr_addr    = addr_q.pop_front();
					wr_req_cyc = req_cyc_q.pop_front();
					check_lsab_wr(lsab_wr, mem_bus_pkg::lsab_wr_t'{write: 1'b1,
						section: exp_section, data: {7'h55, wr_addr}});
					if (cyc != wr_req_cyc + MCU_LATENCY)
						flag_failure("lsab write not at the read latency");
				end
			end
			if (dev_err_ack != '0)
			begin
				ack_count++;
				check_ack(dev_err_ack, 4'b0001 << exp_section);   // own section only
			end
			if (working && !working_prev && cyc != accept_cyc + 1)
				flag_failure("working did not rise the cycle after acceptance");
			if (!working && working_prev && cyc != last_req_cyc + MCU_LATENCY + 1)
				flag_failure("working did not fall latency+1 cycles after the last request");
			if (issue && !working)
				accept_cyc = cyc;                 // accepted at the coming edge
			working_prev = working;
		end
	end

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic run_move(input mover_pkg::move_cmd_t c, input int kind,
			input int stop_after, input bit busy_issue);
		mover_pkg::move_status_t exp_status;
		mover_pkg::move_cmd_t    junk;
		int                      words;
		words       = expected_words(c.start_addr, c.count_req);
		exp_section = c.section;
		exp_sel     = c.dram_sel;
		exp_addr    = c.start_addr - (c.start_addr % 2);   // even first word
		addr_q.delete();
		req_cyc_q.delete();
		req_count   = 0;
		wr_count    = 0;
		ack_count   = 0;
		@(posedge CLK);
		cmd   <= c;
		issue <= 1'b1;
		if (kind == STOP_OTHER)
			dev_err <= ~(4'b0001 << c.section);   // every other section in error
		@(posedge CLK);                          // accepted here
		issue <= 1'b0;
		@(posedge CLK);
		if (busy_issue)
		begin
			junk  = mover_pkg::move_cmd_t'(19'($urandom));
			cmd   <= junk;                       // must be dropped
			issue <= 1'b1;
			@(posedge CLK);
			issue <= 1'b0;
		end
		if (kind == STOP_FULL || kind == STOP_ERR)
		begin
			repeat (stop_after) @(posedge CLK);
			if (kind == STOP_FULL)
				lsab_full <= 4'b0001 << c.section;
			else
				dev_err <= 4'b0001 << c.section;
		end
		while (working !== 1'b0)
			@(posedge CLK);
		lsab_full <= '0;
		dev_err   <= '0;
		if (kind == STOP_NONE || kind == STOP_OTHER)
		begin
			check_count("request count", req_count, words);
			exp_status = '{count_sent: mover_pkg::len_t'(words), abrupt_stop: 1'b0,
			               device_error: 1'b0};
		end
		else
		begin
			if (req_count >= words)
				flag_failure("requests did not stop on full or error");
			exp_status = '{count_sent: mover_pkg::len_t'(req_count), abrupt_stop: 1'b1,
			               device_error: (kind == STOP_ERR)};
		end
		check_count("write count", wr_count, req_count);
		check_count("dev_err_ack pulses", ack_count, (kind == STOP_ERR) ? 1 : 0);
		if (addr_q.size() != 0)
			flag_failure("reads still in flight after working fell");
		check_status(status, exp_status);
		repeat (2) @(posedge CLK);
		check_status(status, exp_status);   // held while idle
	endtask

	initial
	begin
		mover_pkg::move_cmd_t c;
		int                   kind;
		void'($urandom(32'h702165c7));
		RST       = 1'b0;
		issue     = 1'b0;
		cmd       = '0;
		lsab_full = '0;
		dev_err   = '0;
		repeat (5) @(posedge CLK);
		RST <= 1'b1;
		@(posedge CLK);
		if (working !== 1'b0)
			flag_failure("working high out of reset");
		if (mcu_req.access !== '0)
			flag_failure("mcu access active out of reset");
		if (lsab_wr.write !== 1'b0)
			flag_failure("lsab write strobe active out of reset");
		check_ack(dev_err_ack, '0);
		check_status(status, '0);

		for (int i = 0; i < NUM_CMDS; i++)
		begin
			c.start_addr = mover_pkg::addr_t'(($urandom % 200) * 2 + (i % 2));  // even, odd
			c.section    = mover_pkg::section_t'($urandom);
			c.dram_sel   = mover_pkg::dram_sel_t'($urandom % 3 + 1);   // never idle
			if (i < 12)
				kind = STOP_NONE;
			else if (i == 12)
				kind = STOP_OTHER;
			else if (i == 13)
				kind = STOP_FULL;
			else
				kind = STOP_ERR;
			if (kind == STOP_FULL || kind == STOP_ERR)
				c.count_req = mover_pkg::len_t'(30 + $urandom % 11);    // long enough to cut
			else
				c.count_req = mover_pkg::len_t'($urandom % 41);
			run_move(c, kind, 2 + $urandom % 4, (i % 4) == 1);
		end

		$display("run done: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// hang guard
	initial
	begin
		wait (cyc >= TIMEOUT_CYC);
		$display("timeout: run not finished after %0d cycles", TIMEOUT_CYC);
		$display("TEST FAIL");
		$finish;
	end

endmodule
